// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_lsu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
verilog/lsu_pkg.sv
verilog/pipe_reg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_issue_queue.sv
verilog/load_unit.sv
verilog/store_unit.sv
verilog/dmem_arbiter.sv
verilog/lsu_top.sv
test/lsu_assertions.sv
test/tb_lsu.sv

// ==== test/lsu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions import lsu_pkg::*; (
    input logic          clk_i,
    input logic          rst_ni,
    input logic          lsu_valid_i,
    input logic          lsu_ready_i,
    input load_result_t  load_result_i,
    input store_result_t store_result_i,
    input logic          pop_ld_i,
    input logic          pop_st_i,
    input logic          ld_gnt_i,
    input logic          st_gnt_i
);

    // one sticky flag per property
    logic issue_err = 1'b0;
    logic reset_err = 1'b0;
    logic pop_err   = 1'b0;
    logic gnt_err   = 1'b0;
    logic any_fail;

    assign any_fail = issue_err | reset_err | pop_err | gnt_err;

    // ------------------------------
    // issue handshake
    // ------------------------------
    // request only while the queue is empty
    valid_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i |-> lsu_ready_i)
        else begin
            issue_err = 1'b1;
            $error("lsu_valid_i high while lsu_ready_o low");
        end

    // output stages cleared during reset
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !load_result_i.valid && !store_result_i.valid)
        else begin
            reset_err = 1'b1;
            $error("result valid during reset");
        end

    // ------------------------------
    // units and memory port
    // ------------------------------
    one_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i))
        else begin
            pop_err = 1'b1;
            $error("load and store pop in the same cycle");
        end

    one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ld_gnt_i && st_gnt_i))
        else begin
            gnt_err = 1'b1;
            $error("both memory grants high");
        end

endmodule

`default_nettype wire

// ==== test/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

    logic          clk = 1'b0;
    logic          rst_n;
    lsu_req_t      lsu_req;
    logic          lsu_valid;
    logic          lsu_ready;
    load_result_t  load_result;
    store_result_t store_result;

    // reference state
    logic [XLEN-1:0]          model_mem [DMEM_WORDS];
    load_result_t             exp_ld_q [$];
    store_result_t            exp_st_q [$];
    logic [TRANS_ID_BITS-1:0] tid = '0;
    int unsigned              n_issued = 0;
    int                       seed = 32'h2d9c;

    always #5 clk = ~clk;

    lsu_top i_dut (
        .clk_i          ( clk          ),
        .rst_ni         ( rst_n        ),
        .lsu_req_i      ( lsu_req      ),
        .lsu_valid_i    ( lsu_valid    ),
        .lsu_ready_o    ( lsu_ready    ),
        .load_result_o  ( load_result  ),
        .store_result_o ( store_result )
    );

    bind lsu_top lsu_assertions i_assertions (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .lsu_valid_i    ( lsu_valid_i    ),
        .lsu_ready_i    ( lsu_ready_o    ),
        .load_result_i  ( load_result_o  ),
        .store_result_i ( store_result_o ),
        .pop_ld_i       ( pop_ld         ),
        .pop_st_i       ( pop_st         ),
        .ld_gnt_i       ( ld_gnt         ),
        .st_gnt_i       ( st_gnt         )
    );

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t %s", $time, why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    function automatic int access_bytes(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // expected result of one request, byte by byte over the model memory
    function automatic void ref_lsu(input lsu_req_t req);
        logic [63:0]   addr;
        logic [63:0]   val;
        logic [7:0]    idx;
        int            off;
        int            nbytes;
        logic          is_st;
        exception_t    ex;
        load_result_t  ld;
        store_result_t st;
        addr   = req.operand_a + req.imm;
        idx    = addr[10:3];
        off    = int'(addr[2:0]);
        nbytes = access_bytes(req.op);
        is_st  = req.op inside {SB, SH, SW, SD};
        val    = '0;
        ex     = '0;
        // range first, then natural alignment
        if (addr >= 64'(DMEM_WORDS * 8)) begin
            ex = '{valid: 1'b1, cause: is_st ? ST_ACCESS_FAULT : LD_ACCESS_FAULT, tval: addr};
        end else if (off % nbytes != 0) begin
            ex = '{valid: 1'b1, cause: is_st ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED,
                   tval: addr};
        end
        if (is_st) begin
            if (!ex.valid) begin
                for (int i = 0; i < nbytes; i++) begin
                    model_mem[idx][(off + i) * 8 +: 8] = req.operand_b[i * 8 +: 8];
                end
            end
            st = '{valid: 1'b1, trans_id: req.trans_id, ex: ex};
            exp_st_q.push_back(st);
        end else begin
            if (!ex.valid) begin
                for (int i = 0; i < nbytes; i++) begin
                    val[i * 8 +: 8] = model_mem[idx][(off + i) * 8 +: 8];
                end
                // sign fill for the signed sizes
                if ((req.op inside {LB, LH, LW}) && val[nbytes * 8 - 1]) begin
                    for (int i = nbytes * 8; i < 64; i++) begin
                        val[i] = 1'b1;
                    end
                end
            end
            ld = '{valid: 1'b1, trans_id: req.trans_id, data: val, ex: ex};
            exp_ld_q.push_back(ld);
        end
    endfunction

    // drive one request on a falling edge once the queue is empty
    task automatic issue(input lsu_op_e op, input logic [63:0] addr,
                         input logic [63:0] wdata);
        logic [63:0] imm;
        @(negedge clk);
        lsu_valid = 1'b0;
        while (!lsu_ready) begin
            @(negedge clk);
        end
        // small signed offset, base makes up the rest
        imm       = 64'(rand_below(64)) - 64'd32;
        lsu_req   = '{operand_a: addr - imm, imm: imm, operand_b: wdata, op: op,
                      trans_id: tid};
        lsu_valid = 1'b1;
        ref_lsu(lsu_req);
        tid       = tid + 1'b1;
        n_issued++;
    endtask

    // ------------------------------
    // compare
    // ------------------------------
    always @(negedge clk) begin
        load_result_t  exp_ld;
        store_result_t exp_st;
        if (load_result.valid) begin
            if (exp_ld_q.size() == 0) begin
                abort_run("load result arrived with no load outstanding");
            end else begin
                exp_ld = exp_ld_q.pop_front();
                check_value("load_result_o.trans_id", 64'(exp_ld.trans_id),
                            64'(load_result.trans_id));
                check_value("load_result_o.data", exp_ld.data, load_result.data);
                check_value("load_result_o.ex.valid", 64'(exp_ld.ex.valid),
                            64'(load_result.ex.valid));
                check_value("load_result_o.ex.cause", 64'(exp_ld.ex.cause),
                            64'(load_result.ex.cause));
                check_value("load_result_o.ex.tval", exp_ld.ex.tval, load_result.ex.tval);
            end
        end
        if (store_result.valid) begin
            if (exp_st_q.size() == 0) begin
                abort_run("store result arrived with no store outstanding");
            end else begin
                exp_st = exp_st_q.pop_front();
                check_value("store_result_o.trans_id", 64'(exp_st.trans_id),
                            64'(store_result.trans_id));
                check_value("store_result_o.ex.valid", 64'(exp_st.ex.valid),
                            64'(store_result.ex.valid));
                check_value("store_result_o.ex.cause", 64'(exp_st.ex.cause),
                            64'(store_result.ex.cause));
                check_value("store_result_o.ex.tval", exp_st.ex.tval, store_result.ex.tval);
            end
        end
    end

    // limit grows with every request issued
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > n_issued * 10 + 1000 + 16) begin
                abort_run($sformatf("timeout after %0d cycles, %0d loads %0d stores pending",
                                    cycles, exp_ld_q.size(), exp_st_q.size()));
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus
        lsu_op_e op;
        int      nb;
        int      off;
        rst_n     = 1'b0;
        lsu_valid = 1'b0;
        lsu_req   = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // idle after reset, ready and no stray results
        repeat (5) @(negedge clk);
        check_value("lsu_ready_o", 64'd1, 64'(lsu_ready));

        // fill words 0..63, then narrow stores on top
        for (int w = 0; w < 64; w++) begin
            issue(SD, 64'(w * 8), rand64());
        end
        for (int w = 0; w < 8; w++) begin
            issue(SB, 64'(w * 8 + w), rand64());
            issue(SH, 64'(w * 8 + 2 * (w % 4)), rand64());
            issue(SW, 64'(w * 8 + 4 * (w % 2)), rand64());
        end
        // every load size and extension
        for (int w = 0; w < 16; w++) begin
            for (int k = 0; k < 7; k++) begin
                op  = lsu_op_e'(4'(k));
                nb  = access_bytes(op);
                off = ((w + k) % (8 / nb)) * nb;
                issue(op, 64'(w * 8 + off), 64'd0);
            end
        end

        // misaligned, memory must stay as it was
        issue(LH, 64'h29, 64'd0);
        issue(LW, 64'h2a, 64'd0);
        issue(LD, 64'h2c, 64'd0);
        issue(SH, 64'h2b, rand64());
        issue(SW, 64'h2e, rand64());
        issue(SD, 64'h2d, rand64());
        issue(LD, 64'h28, 64'd0);

        // range faults, also ahead of misalignment
        issue(LD, 64'h800, 64'd0);
        issue(LH, 64'h801, 64'd0);
        issue(SW, 64'h1000_0000, rand64());
        issue(SD, 64'hffff_ffff_ffff_fff9, rand64());
        issue(LBU, 64'h8000_0000_0000_0000, 64'd0);

        // store then load of the same word, back to back
        issue(SD, 64'h140, rand64());
        issue(LD, 64'h140, 64'd0);
        issue(SW, 64'h144, rand64());
        issue(LWU, 64'h144, 64'd0);

        // random mix over the written words
        for (int n = 0; n < 500; n++) begin
            op  = lsu_op_e'(4'(rand_below(11)));
            nb  = access_bytes(op);
            off = int'(rand_below(8 / nb)) * nb;
            issue(op, 64'(int'(rand_below(64)) * 8 + off), rand64());
        end

        @(negedge clk);
        lsu_valid = 1'b0;
        while (exp_ld_q.size() != 0 || exp_st_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        if (!i_dut.i_assertions.any_fail) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failure during run");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dmem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter import lsu_pkg::*; (
    input  logic            clk_i,
    input  dmem_req_t       ld_req_i,
    input  dmem_req_t       st_req_i,
    output logic            ld_gnt_o,
    output logic            st_gnt_o,
    output logic [XLEN-1:0] rdata_o
);

    logic [XLEN-1:0] mem_q [DMEM_WORDS];
    logic [XLEN-1:0] rdata_q;
    dmem_req_t       sel;
    logic [XLEN-1:0] bit_mask;

    // ------------------------------
    // fixed priority
    // ------------------------------
    // store side first
    assign st_gnt_o = st_req_i.req;
    assign ld_gnt_o = ld_req_i.req && !st_req_i.req;

    // winning request drives the single port
    assign sel = st_req_i.req ? st_req_i : ld_req_i;

    // byte enables widened to bits
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            bit_mask[i*8 +: 8] = {8{sel.be[i]}};
        end
    end

    // ------------------------------
    // data memory
    // ------------------------------
    // write lands at the edge of its grant
    always_ff @(posedge clk_i) begin
        if (sel.req && sel.we) begin
            mem_q[sel.idx] <= (mem_q[sel.idx] & ~bit_mask) | (sel.wdata & bit_mask);
        end
    end

    // registered read, holds the last word otherwise
    always_ff @(posedge clk_i) begin
        if (sel.req && !sel.we) begin
            rdata_q <= mem_q[sel.idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  lsu_ctrl_t       ctrl_i,
    output logic            pop_ld_o,
    output dmem_req_t       mem_req_o,
    input  logic            mem_gnt_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output load_result_t    result_o
);

    logic                     ld_hit;
    logic                     ld_mem;
    // state of the load in flight
    logic                     valid_q;
    lsu_op_e                  op_q;
    logic [2:0]               off_q;
    logic [TRANS_ID_BITS-1:0] tid_q;
    exception_t               ex_q;
    logic [XLEN-1:0]          shifted;
    logic [XLEN-1:0]          aligned;

    assign ld_hit = ctrl_i.valid && is_load(ctrl_i.op);
    // excepted loads never touch memory
    assign ld_mem = ld_hit && !ctrl_i.ex.valid;

    assign mem_req_o = '{req: ld_mem, we: 1'b0, idx: ctrl_i.vaddr[DMEM_ADDR_BITS+2:3],
                         be: ctrl_i.be, wdata: {XLEN{1'b0}}};

    // lost arbitration leaves the entry in the queue for a retry
    assign pop_ld_o = ld_hit && (ctrl_i.ex.valid || mem_gnt_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_ld_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_ld_o) begin
            op_q  <= ctrl_i.op;
            off_q <= ctrl_i.vaddr[2:0];
            tid_q <= ctrl_i.trans_id;
            ex_q  <= ctrl_i.ex;
        end
    end

    // ------------------------------
    // data alignment
    // ------------------------------
    assign shifted = mem_rdata_i >> {off_q, 3'b000};

    always_comb begin
        unique case (op_q)
            LB:      aligned = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            LBU:     aligned = {{(XLEN-8){1'b0}}, shifted[7:0]};
            LH:      aligned = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            LHU:     aligned = {{(XLEN-16){1'b0}}, shifted[15:0]};
            LW:      aligned = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            LWU:     aligned = {{(XLEN-32){1'b0}}, shifted[31:0]};
            default: aligned = shifted;
        endcase
    end

    // read word arrives the cycle after the grant
    assign result_o = '{valid: valid_q, trans_id: tid_q,
                        data: ex_q.valid ? {XLEN{1'b0}} : aligned, ex: ex_q};

endmodule

`default_nettype wire

// ==== verilog/lsu_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen import lsu_pkg::*; (
    input  lsu_req_t  lsu_req_i,
    input  logic      lsu_valid_i,
    output lsu_ctrl_t ctrl_o
);

    logic [XLEN-1:0] vaddr;
    logic [1:0]      size;
    logic [7:0]      be_base;
    logic            misaligned;
    logic            range_fault;
    logic            ld_op;
    logic            st_op;

    // base plus sign-extended immediate, wraps at 64 bits
    assign vaddr = lsu_req_i.operand_a + lsu_req_i.imm;

    assign ld_op = is_load(lsu_req_i.op);
    assign st_op = is_store(lsu_req_i.op);

    // access size as log2 of bytes
    always_comb begin
        unique case (lsu_req_i.op)
            LH, LHU, SH: size = 2'd1;
            LW, LWU, SW: size = 2'd2;
            LD, SD:      size = 2'd3;
            default:     size = 2'd0;
        endcase
    end

    // ------------------------------
    // byte enables and misalignment
    // ------------------------------
    always_comb begin
        unique case (size)
            2'd1:    be_base = 8'h03;
            2'd2:    be_base = 8'h0f;
            2'd3:    be_base = 8'hff;
            default: be_base = 8'h01;
        endcase
    end

    always_comb begin
        unique case (size)
            2'd1:    misaligned = vaddr[0];
            2'd2:    misaligned = |vaddr[1:0];
            2'd3:    misaligned = |vaddr[2:0];
            default: misaligned = 1'b0;
        endcase
    end

    // anything past the on-chip data memory faults
    assign range_fault = |vaddr[XLEN-1:DMEM_BYTES_LOG2];

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.valid    = lsu_valid_i;
        ctrl_o.vaddr    = vaddr;
        // store data moved into its byte lanes
        ctrl_o.wdata    = lsu_req_i.operand_b << {vaddr[2:0], 3'b000};
        ctrl_o.be       = be_base << vaddr[2:0];
        ctrl_o.op       = lsu_req_i.op;
        ctrl_o.trans_id = lsu_req_i.trans_id;
        // fault wins over misalignment
        if (lsu_valid_i && (ld_op || st_op) && (range_fault || misaligned)) begin
            ctrl_o.ex.valid = 1'b1;
            ctrl_o.ex.tval  = vaddr;
            if (range_fault) begin
                ctrl_o.ex.cause = ld_op ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            end else begin
                ctrl_o.ex.cause = ld_op ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_queue import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t req_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    // two-entry ring
    lsu_ctrl_t  mem_q [2];
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic       empty;
    logic       push;
    logic       pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    assign push = req_i.valid;
    // only one unit matches the head operator
    assign pop  = pop_ld_i | pop_st_i;

    // empty queue hands the new entry through untouched
    assign ctrl_o = empty ? req_i : mem_q[rd_ptr_q];

    // ------------------------------
    // pointers and count
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            // push and pop together keep the count
            if (push && !pop) begin
                cnt_q <= cnt_q + 2'd1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 2'd1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
        // bypassed entry lands invalid when popped in the same cycle
        if (pop) begin
            mem_q[rd_ptr_q].valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int unsigned XLEN            = 64;
    localparam int unsigned TRANS_ID_BITS   = 3;
    localparam int unsigned DMEM_WORDS      = 256;
    localparam int unsigned DMEM_ADDR_BITS  = 8;
    // byte addresses below this bit land in the data memory
    localparam int unsigned DMEM_BYTES_LOG2 = 11;

    // exception cause codes
    localparam logic [3:0] LD_ADDR_MISALIGNED = 4'd4;
    localparam logic [3:0] LD_ACCESS_FAULT    = 4'd5;
    localparam logic [3:0] ST_ADDR_MISALIGNED = 4'd6;
    localparam logic [3:0] ST_ACCESS_FAULT    = 4'd7;

    // ------------------------------
    // types
    // ------------------------------
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_e;

    // request from the issue stage
    typedef struct packed {
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          operand_b;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        logic [3:0]      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // one issue queue entry
    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          wdata;
        logic [7:0]               be;
        lsu_op_e                  op;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } lsu_ctrl_t;

    // word-wide memory port request
    typedef struct packed {
        logic                      req;
        logic                      we;
        logic [DMEM_ADDR_BITS-1:0] idx;
        logic [7:0]                be;
        logic [XLEN-1:0]           wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
        exception_t               ex;
    } load_result_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } store_result_t;

    // operator classes
    function automatic logic is_load(lsu_op_e op);
        return op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    endfunction

    function automatic logic is_store(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  lsu_req_t      lsu_req_i,
    input  logic          lsu_valid_i,
    output logic          lsu_ready_o,
    output load_result_t  load_result_o,
    output store_result_t store_result_o
);

    // new entry straight from the address generator
    lsu_ctrl_t     lsu_ctrl;
    // entry presented to both units
    lsu_ctrl_t     issue_ctrl;
    logic          pop_ld;
    logic          pop_st;

    // memory side
    dmem_req_t     ld_mem_req;
    dmem_req_t     st_mem_req;
    logic          ld_gnt;
    logic          st_gnt;
    logic [XLEN-1:0] mem_rdata;

    // unregistered results
    load_result_t  ld_result;
    store_result_t st_result;

    // ------------------------------
    // issue side
    // ------------------------------
    lsu_addr_gen i_addr_gen (
        .lsu_req_i   ( lsu_req_i   ),
        .lsu_valid_i ( lsu_valid_i ),
        .ctrl_o      ( lsu_ctrl    )
    );

    lsu_issue_queue i_issue_queue (
        .clk_i,
        .rst_ni,
        .req_i    ( lsu_ctrl    ),
        .pop_ld_i ( pop_ld      ),
        .pop_st_i ( pop_st      ),
        .ctrl_o   ( issue_ctrl  ),
        .ready_o  ( lsu_ready_o )
    );

    // ------------------------------
    // units and memory
    // ------------------------------
    load_unit i_load_unit (
        .clk_i,
        .rst_ni,
        .ctrl_i      ( issue_ctrl ),
        .pop_ld_o    ( pop_ld     ),
        .mem_req_o   ( ld_mem_req ),
        .mem_gnt_i   ( ld_gnt     ),
        .mem_rdata_i ( mem_rdata  ),
        .result_o    ( ld_result  )
    );

    store_unit i_store_unit (
        .clk_i,
        .rst_ni,
        .ctrl_i    ( issue_ctrl ),
        .pop_st_o  ( pop_st     ),
        .mem_req_o ( st_mem_req ),
        .mem_gnt_i ( st_gnt     ),
        .result_o  ( st_result  )
    );

    // store side wins, keeps a younger load behind an older store
    dmem_arbiter i_dmem_arbiter (
        .clk_i,
        .ld_req_i ( ld_mem_req ),
        .st_req_i ( st_mem_req ),
        .ld_gnt_o ( ld_gnt     ),
        .st_gnt_o ( st_gnt     ),
        .rdata_o  ( mem_rdata  )
    );

    // ------------------------------
    // output registers
    // ------------------------------
    pipe_reg #(.payload_t(load_result_t)) i_load_reg (
        .clk_i,
        .rst_ni,
        .d_i ( ld_result     ),
        .q_o ( load_result_o )
    );

    pipe_reg #(.payload_t(store_result_t)) i_store_reg (
        .clk_i,
        .rst_ni,
        .d_i ( st_result      ),
        .q_o ( store_result_o )
    );

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    // whole stage clears, valid bit included
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            q <= '0;
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

`default_nettype wire

// ==== verilog/store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_unit import lsu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  lsu_ctrl_t     ctrl_i,
    output logic          pop_st_o,
    output dmem_req_t     mem_req_o,
    input  logic          mem_gnt_i,
    output store_result_t result_o
);

    logic                      st_hit;
    logic                      buf_free;
    logic                      buf_load;
    // write buffer
    logic                      buf_valid_q;
    logic [DMEM_ADDR_BITS-1:0] buf_idx_q;
    logic [7:0]                buf_be_q;
    logic [XLEN-1:0]           buf_wdata_q;
    // result register
    logic                      res_valid_q;
    logic [TRANS_ID_BITS-1:0]  res_tid_q;
    exception_t                res_ex_q;

    assign st_hit   = ctrl_i.valid && is_store(ctrl_i.op);
    // buffer drains in this cycle or is already empty
    assign buf_free = !buf_valid_q || mem_gnt_i;

    // excepted stores need no buffer slot
    assign pop_st_o = st_hit && (ctrl_i.ex.valid || buf_free);
    assign buf_load = pop_st_o && !ctrl_i.ex.valid;

    // ------------------------------
    // write buffer
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            buf_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            if (buf_load) begin
                buf_valid_q <= 1'b1;
            end else if (mem_gnt_i) begin
                buf_valid_q <= 1'b0;
            end
            res_valid_q <= pop_st_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (buf_load) begin
            buf_idx_q   <= ctrl_i.vaddr[DMEM_ADDR_BITS+2:3];
            buf_be_q    <= ctrl_i.be;
            buf_wdata_q <= ctrl_i.wdata;
        end
        if (pop_st_o) begin
            res_tid_q <= ctrl_i.trans_id;
            res_ex_q  <= ctrl_i.ex;
        end
    end

    // masked write, held until granted
    assign mem_req_o = '{req: buf_valid_q, we: 1'b1, idx: buf_idx_q,
                         be: buf_be_q, wdata: buf_wdata_q};

    // reported on pop, ahead of the write itself
    assign result_o = '{valid: res_valid_q, trans_id: res_tid_q, ex: res_ex_q};

endmodule

`default_nettype wire
